// ==== design/edm_pkg.sv ====
package edm_pkg;

	typedef logic signed [15:0] sample_t; // adc code, gap current or gap voltage
	typedef logic [15:0] time_us_t; // host time setting in us
	typedef logic [31:0] cycles_t; // count of 10 ns clk cycles
	typedef logic [15:0] waveform_t; // host waveform select code

	// one half-bridge, bit 1 upper mosfet, bit 0 lower mosfet
	typedef logic [1:0] half_bridge_t;

	localparam half_bridge_t HB_OFF = 2'b00; // both mosfets open
	localparam half_bridge_t HB_UP = 2'b10; // upper on, bridge tied to supply
	localparam half_bridge_t HB_DOWN = 2'b01; // lower on, freewheel / discharge

	typedef struct packed {
		half_bridge_t buck1; // buck phase 0
		half_bridge_t buck2; // buck phase 180
		half_bridge_t res1; // resistor branch, feeds open voltage while waiting
		half_bridge_t res2; // second resistor branch
		logic deion; // qoff switch, clamps the gap during off time
	} gate_cmd_t;

	typedef enum logic [1:0] {
		S_DEION, // off time, gap recovers
		S_WAIT_BREAKDOWN, // open voltage applied, waiting for the gap to fire
		S_BUCK, // interleaved buck discharge
		S_RES // resistor discharge
	} pulse_state_t;

	localparam waveform_t WAVE_RES = 16'h8000; // resistor discharge, continuous
	localparam waveform_t WAVE_BUCK_OPEN = 16'h0001; // open-loop interleaved buck

	localparam cycles_t CYCLES_PER_US = 32'd100; // 100 MHz clk
	localparam cycles_t BUCK_PERIOD = 32'd400; // 4 us switching period, 250 kHz
	localparam cycles_t BUCK_HALF = 32'd200; // phase offset of the second buck leg

	localparam gate_cmd_t GATE_IDLE = '{
		buck1: HB_OFF, buck2: HB_OFF, res1: HB_OFF, res2: HB_OFF, deion: 1'b0
	}; // everything open, used as dead time

	// interpulse, all lower mosfets on and qoff closed
	localparam gate_cmd_t GATE_DEION = '{
		buck1: HB_DOWN, buck2: HB_DOWN, res1: HB_DOWN, res2: HB_DOWN, deion: 1'b1
	};

	localparam gate_cmd_t GATE_WAIT = '{
		buck1: HB_OFF, buck2: HB_OFF, res1: HB_UP, res2: HB_OFF, deion: 1'b0
	}; // open voltage through res1, also the resistor discharge pattern

endpackage

// ==== design/pulse_sequencer.sv ====
`timescale 1ns/1ps

module pulse_sequencer
#(
	parameter int unsigned DEAD_TIME = 10, // cycles, both edges of the deion window
	parameter int unsigned WAIT_MAX = 10000, // longest wait for breakdown, cycles
	parameter int MAX_CURRENT = 76 // total current trip level, adc codes
)
(
	input logic clk,
	input logic rst_n,
	input logic machine_on, // host run request
	input edm_pkg::waveform_t waveform,
	input edm_pkg::time_us_t ton, // on time, us
	input edm_pkg::time_us_t toff, // off time, us
	input edm_pkg::sample_t sample_current, // one phase current
	input logic is_breakdown, // from breakdown_detector
	output edm_pkg::pulse_state_t state,
	output edm_pkg::cycles_t state_timer, // cycles spent in the current state
	output edm_pkg::cycles_t toff_cycles,
	output logic is_operation
);

	// deion window must fit two dead times
	localparam edm_pkg::cycles_t TOFF_MIN = edm_pkg::cycles_t'(2 * DEAD_TIME);

	edm_pkg::sample_t total_current; // both phases together
	logic is_overcurrent;
	edm_pkg::cycles_t ton_cycles;
	edm_pkg::cycles_t toff_scaled;
	edm_pkg::pulse_state_t next_state;
	logic off_done; // last cycle of the off time
	logic on_done; // last cycle of the pulse
	logic in_window; // still inside the breakdown window

	assign toff_scaled = edm_pkg::cycles_t'(toff) * edm_pkg::CYCLES_PER_US;
	assign off_done = (state_timer + 32'd1) >= toff_cycles; // timer reaches toff next edge
	assign on_done = (state_timer + 32'd1) >= ton_cycles;
	assign in_window = state_timer <= WAIT_MAX;

	// sample reg, overcurrent reg, operation reg, three cycles to trip
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			total_current <= '0;
			is_overcurrent <= 1'b0;
			is_operation <= 1'b0;
		end
		else
		begin
			total_current <= sample_current <<< 1; // phases share the load equally
			is_overcurrent <= total_current > MAX_CURRENT;
			is_operation <= machine_on && !is_overcurrent;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ton_cycles <= '0;
			toff_cycles <= TOFF_MIN;
		end
		else
		begin
			ton_cycles <= edm_pkg::cycles_t'(ton) * edm_pkg::CYCLES_PER_US; // us to cycles
			toff_cycles <= (toff_scaled < TOFF_MIN) ? TOFF_MIN : toff_scaled;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= edm_pkg::S_DEION;
			state_timer <= '0;
		end
		else
		begin
			state <= next_state;
			if (next_state != state)
				state_timer <= '0; // every state starts counting at zero
			else
				state_timer <= state_timer + 32'd1;
		end
	end

	always_comb
	begin
		next_state = state;
		case (state)
			edm_pkg::S_DEION:
			begin
				if (off_done && is_operation)
					next_state = edm_pkg::S_WAIT_BREAKDOWN; // hold off time while stopped
			end
			edm_pkg::S_WAIT_BREAKDOWN:
			begin
				if (!is_operation)
					next_state = edm_pkg::S_DEION; // stop or overcurrent
				else if (is_breakdown && in_window)
				begin
					if (waveform == edm_pkg::WAVE_BUCK_OPEN)
						next_state = edm_pkg::S_BUCK;
					else if (waveform == edm_pkg::WAVE_RES)
						next_state = edm_pkg::S_RES;
					else
						next_state = edm_pkg::S_DEION; // unsupported code, no pulse
				end
				else if (!in_window)
					next_state = edm_pkg::S_DEION; // timeout, late breakdown counts too
			end
			edm_pkg::S_BUCK:
			begin
				if (on_done)
					next_state = edm_pkg::S_DEION;
			end
			edm_pkg::S_RES:
			begin
				if (on_done || !is_operation)
					next_state = edm_pkg::S_DEION;
			end
			default:
				next_state = edm_pkg::S_DEION;
		endcase
	end

	// every 2-bit code is a state, so only an unknown value leaves the enum
	a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown(state));

endmodule

// ==== design/breakdown_detector.sv ====
`timescale 1ns/1ps

module breakdown_detector
#(
	parameter int BRK_CUR = 10, // gap current must rise above this
	parameter int BRK_VOL = 40, // gap voltage must fall below this
	parameter int unsigned BRK_TIME = 10 // consecutive qualifying cycles
)
(
	input logic clk,
	input logic rst_n,
	input edm_pkg::pulse_state_t state,
	input edm_pkg::sample_t sample_current,
	input edm_pkg::sample_t sample_voltage,
	output logic is_breakdown
);

	localparam int unsigned CNT_W = $clog2(BRK_TIME + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(BRK_TIME - 1);

	logic [CNT_W-1:0] qual_cnt; // cycles the gap has looked fired
	logic brk_hit; // sticky until the wait ends
	logic waiting;
	logic gap_cond; // current flowing and voltage collapsed

	assign waiting = state == edm_pkg::S_WAIT_BREAKDOWN;
	assign gap_cond = (sample_current > BRK_CUR) && (sample_voltage < BRK_VOL);
	assign is_breakdown = brk_hit && waiting; // drops with the state, no extra cycle

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			qual_cnt <= '0;
			brk_hit <= 1'b0;
		end
		else if (!waiting)
		begin
			qual_cnt <= '0; // fresh qualification on every wait
			brk_hit <= 1'b0;
		end
		else if (!brk_hit)
		begin
			if (!gap_cond)
				qual_cnt <= '0; // noise spike, start over
			else if (qual_cnt == CNT_LAST)
				brk_hit <= 1'b1;
			else
				qual_cnt <= qual_cnt + 1'b1;
		end
	end

endmodule

// ==== design/buck_phase_gen.sv ====
`timescale 1ns/1ps

module buck_phase_gen
#(
	parameter int unsigned DEAD_TIME = 10, // cycles around each upper mosfet pulse
	parameter int unsigned CHARGE_TIME = 80 // inductor charging time per period, cycles
)
(
	input logic clk,
	input logic rst_n,
	input edm_pkg::pulse_state_t state,
	output edm_pkg::gate_cmd_t buck_pat // buck1/buck2 only, rest idle
);

	localparam edm_pkg::cycles_t UP_START = edm_pkg::cycles_t'(DEAD_TIME);
	localparam edm_pkg::cycles_t UP_END = edm_pkg::cycles_t'(DEAD_TIME + CHARGE_TIME);
	// end of the switching pattern, also where phase 180 parks
	localparam edm_pkg::cycles_t PAT_END = edm_pkg::cycles_t'(2 * DEAD_TIME + CHARGE_TIME);

	edm_pkg::cycles_t timer_0; // phase 0 position in the period
	edm_pkg::cycles_t timer_180; // phase 180 position, restarted half a period later
	logic in_buck;

	// off, charge, off, freewheel
	function automatic edm_pkg::half_bridge_t phase_pattern(edm_pkg::cycles_t t);
		if (t < UP_START)
			return edm_pkg::HB_OFF; // lower mosfet turning off
		else if (t < UP_END)
			return edm_pkg::HB_UP; // charge inductor
		else if (t < PAT_END)
			return edm_pkg::HB_OFF; // upper mosfet turning off
		else
			return edm_pkg::HB_DOWN; // inductor discharges into the gap
	endfunction

	assign in_buck = state == edm_pkg::S_BUCK;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			timer_0 <= '0;
		else if (!in_buck)
			timer_0 <= '0; // first period starts with the pulse
		else if (timer_0 == edm_pkg::BUCK_PERIOD - 32'd1)
			timer_0 <= '0;
		else
			timer_0 <= timer_0 + 32'd1;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			timer_180 <= PAT_END;
		else if (!in_buck)
			timer_180 <= PAT_END; // parked in freewheel until its first start
		else if (timer_0 == edm_pkg::BUCK_HALF - 32'd1)
			timer_180 <= '0; // locked to phase 0, 180 degrees later
		else if (timer_180 < PAT_END)
			timer_180 <= timer_180 + 32'd1; // stops once the pattern is done
	end

	always_comb
	begin
		buck_pat = edm_pkg::GATE_IDLE;
		buck_pat.buck1 = phase_pattern(timer_0);
		buck_pat.buck2 = phase_pattern(timer_180);
	end

	// phase 180 must finish its pulse before phase 0 wraps
	a_pattern_fits: assert property (@(posedge clk) PAT_END < edm_pkg::BUCK_HALF);

endmodule

// ==== design/gate_driver.sv ====
`timescale 1ns/1ps

module gate_driver
#(
	parameter int unsigned DEAD_TIME = 10 // all-open cycles around the deion window
)
(
	input logic clk,
	input logic rst_n,
	input edm_pkg::pulse_state_t state,
	input edm_pkg::cycles_t state_timer,
	input edm_pkg::cycles_t toff_cycles,
	input edm_pkg::gate_cmd_t buck_pat,
	output edm_pkg::gate_cmd_t gate // registered mosfet commands
);

	edm_pkg::gate_cmd_t gate_next;
	edm_pkg::cycles_t deion_end; // deion window closes here

	function automatic logic any_short(edm_pkg::gate_cmd_t g);
		return (g.buck1 == 2'b11) || (g.buck2 == 2'b11) || (g.res1 == 2'b11) || (g.res2 == 2'b11);
	endfunction

	// up to down or down to up without passing through off
	function automatic logic hard_switch(edm_pkg::half_bridge_t a, edm_pkg::half_bridge_t b);
		return ((a == edm_pkg::HB_UP) && (b == edm_pkg::HB_DOWN))
			|| ((a == edm_pkg::HB_DOWN) && (b == edm_pkg::HB_UP));
	endfunction

	assign deion_end = toff_cycles - DEAD_TIME; // toff_cycles holds at least two dead times

	always_comb
	begin
		gate_next = edm_pkg::GATE_IDLE;
		case (state)
			edm_pkg::S_DEION:
			begin
				if ((state_timer >= DEAD_TIME) && (state_timer < deion_end))
					gate_next = edm_pkg::GATE_DEION; // open before and after, dead time
			end
			edm_pkg::S_WAIT_BREAKDOWN, edm_pkg::S_RES:
				gate_next = edm_pkg::GATE_WAIT; // res1 up, same pattern waits and discharges
			edm_pkg::S_BUCK:
			begin
				gate_next.buck1 = buck_pat.buck1;
				gate_next.buck2 = buck_pat.buck2;
			end
			default:
				gate_next = edm_pkg::GATE_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			gate <= edm_pkg::GATE_IDLE;
		else
			gate <= gate_next; // one cycle behind state and timer
	end

	a_no_short: assert property (@(posedge clk) disable iff (!rst_n) !any_short(gate));

	a_dead_time: assert property (@(posedge clk) disable iff (!rst_n)
		!(hard_switch($past(gate.buck1), gate.buck1) || hard_switch($past(gate.buck2), gate.buck2)
		|| hard_switch($past(gate.res1), gate.res1) || hard_switch($past(gate.res2), gate.res2)));

endmodule

// ==== design/edm_pulse_top.sv ====
`timescale 1ns/1ps

module edm_pulse_top
#(
	parameter int unsigned DEAD_TIME = 10, // 100 ns
	parameter int unsigned WAIT_MAX = 10000, // 100 us
	parameter int MAX_CURRENT = 76, // total current trip, adc codes
	parameter int BRK_CUR = 10,
	parameter int BRK_VOL = 40,
	parameter int unsigned BRK_TIME = 10, // 100 ns qualification
	parameter int unsigned CHARGE_TIME = 80 // 800 ns inductor charge
)
(
	input logic clk, // 100 MHz
	input logic rst_n,
	input logic machine_on,
	input edm_pkg::waveform_t waveform,
	input edm_pkg::time_us_t ton,
	input edm_pkg::time_us_t toff,
	input edm_pkg::sample_t sample_current,
	input edm_pkg::sample_t sample_voltage,
	output edm_pkg::gate_cmd_t gate,
	output logic is_operation,
	output logic is_breakdown
);

	edm_pkg::pulse_state_t state;
	edm_pkg::cycles_t state_timer;
	edm_pkg::cycles_t toff_cycles;
	edm_pkg::gate_cmd_t buck_pat; // buck fields only

	pulse_sequencer #(.DEAD_TIME(DEAD_TIME), .WAIT_MAX(WAIT_MAX), .MAX_CURRENT(MAX_CURRENT))
	u_seq (
		.clk(clk),
		.rst_n(rst_n),
		.machine_on(machine_on),
		.waveform(waveform),
		.ton(ton),
		.toff(toff),
		.sample_current(sample_current),
		.is_breakdown(is_breakdown),
		.state(state),
		.state_timer(state_timer),
		.toff_cycles(toff_cycles),
		.is_operation(is_operation)
	);

	breakdown_detector #(.BRK_CUR(BRK_CUR), .BRK_VOL(BRK_VOL), .BRK_TIME(BRK_TIME))
	u_brk (
		.clk(clk),
		.rst_n(rst_n),
		.state(state),
		.sample_current(sample_current),
		.sample_voltage(sample_voltage),
		.is_breakdown(is_breakdown)
	);

	buck_phase_gen #(.DEAD_TIME(DEAD_TIME), .CHARGE_TIME(CHARGE_TIME))
	u_buck (
		.clk(clk),
		.rst_n(rst_n),
		.state(state),
		.buck_pat(buck_pat)
	);

	gate_driver #(.DEAD_TIME(DEAD_TIME))
	u_gate (
		.clk(clk),
		.rst_n(rst_n),
		.state(state),
		.state_timer(state_timer),
		.toff_cycles(toff_cycles),
		.buck_pat(buck_pat),
		.gate(gate)
	);

endmodule

// ==== verification/tb_edm_pulse.sv ====
`timescale 1ns/1ps

module tb_edm_pulse;

	localparam edm_pkg::cycles_t DEAD_TIME = 32'd10; // dut defaults
	localparam edm_pkg::cycles_t WAIT_MAX = 32'd10000;
	localparam edm_pkg::cycles_t BRK_TIME = 32'd10;
	localparam edm_pkg::cycles_t CHARGE_TIME = 32'd80;
	localparam edm_pkg::cycles_t BUCK_HALF = 32'd200; // second leg offset
	localparam int MAX_CURRENT = 76;
	localparam int BRK_VOL = 40;
	localparam int N_ROWS = 7;
	localparam int G_RES1_UP = 0; // wait conditions on the gate outputs
	localparam int G_RES1_OFF = 1;
	localparam int G_DEION = 2;

	typedef struct packed {
		logic [63:0] name; // up to 8 chars
		edm_pkg::waveform_t wave;
		edm_pkg::time_us_t ton;
		edm_pkg::time_us_t toff;
		logic mon; // machine_on for the row
		edm_pkg::sample_t cur_pre, vol_pre; // gap open levels
		edm_pkg::sample_t cur_brk, vol_brk; // levels applied while waiting
		logic [7:0] exp_up1, exp_up2; // charge pulses per leg and pulse
	} row_t;

	// current above half of MAX_CURRENT trips, voltage at or above BRK_VOL never fires
	localparam row_t ROWS [N_ROWS] = '{
		'{"idle", edm_pkg::WAVE_RES, 16'd5, 16'd3, 1'b0, 16'sd0, 16'sd100, 16'sd0, 16'sd100, 8'd0, 8'd0},
		'{"res", edm_pkg::WAVE_RES, 16'd5, 16'd4, 1'b1, 16'sd0, 16'sd100, 16'sd20, 16'sd10, 8'd0, 8'd0},
		'{"buck", edm_pkg::WAVE_BUCK_OPEN, 16'd10, 16'd6, 1'b1, 16'sd0, 16'sd100, 16'sd20, 16'sd10,
			8'd3, 8'd2},
		'{"timeout", edm_pkg::WAVE_BUCK_OPEN, 16'd10, 16'd3, 1'b1, 16'sd0, 16'sd100, 16'sd20, 16'sd200,
			8'd0, 8'd0},
		'{"overcur", edm_pkg::WAVE_RES, 16'd5, 16'd3, 1'b1, 16'sd0, 16'sd100, 16'sd50, 16'sd10, 8'd0, 8'd0},
		'{"stop", edm_pkg::WAVE_RES, 16'd5, 16'd3, 1'b0, 16'sd0, 16'sd100, 16'sd0, 16'sd100, 8'd0, 8'd0},
		'{"res_b", edm_pkg::WAVE_RES, 16'd2, 16'd2, 1'b1, 16'sd0, 16'sd100, 16'sd25, 16'sd5, 8'd0, 8'd0}
	};

	logic clk;
	logic rst_n;
	logic machine_on;
	edm_pkg::waveform_t waveform;
	edm_pkg::time_us_t ton;
	edm_pkg::time_us_t toff;
	edm_pkg::sample_t sample_current;
	edm_pkg::sample_t sample_voltage;
	edm_pkg::gate_cmd_t gate;
	logic is_operation;
	logic is_breakdown;

	edm_pkg::cycles_t cyc = '0; // negedge count
	edm_pkg::cycles_t idle_run = '0; // consecutive all-off cycles
	edm_pkg::cycles_t deion_len = '0;
	edm_pkg::cycles_t deion_exp = '0;
	edm_pkg::cycles_t b1_len = '0, b2_len = '0, b1_start = '0;
	edm_pkg::cycles_t up1_cnt = '0, up2_cnt = '0; // finished charge pulses
	logic deion_prev = 1'b0;
	logic after_deion = 1'b0;
	logic buck_allowed = 1'b0; // only inside a buck pulse
	logic brk_seen = 1'b0; // is_breakdown pulsed during the wait
	int low_cycles = 0; // cycles with machine_on low

	edm_pulse_top u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.machine_on(machine_on),
		.waveform(waveform),
		.ton(ton),
		.toff(toff),
		.sample_current(sample_current),
		.sample_voltage(sample_voltage),
		.gate(gate),
		.is_operation(is_operation),
		.is_breakdown(is_breakdown)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 10 MHz sim clock, dut counts cycles only
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_gate(input string name, input edm_pkg::gate_cmd_t exp, input edm_pkg::gate_cmd_t act);
		if (act !== exp)
			fail_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_bridge(input string name, input edm_pkg::half_bridge_t exp,
		input edm_pkg::half_bridge_t act);
		if (act !== exp)
			fail_run($sformatf("mismatch %s: expected %b, actual %b", name, exp, act));
	endtask

	task automatic check_cycles(input string name, input edm_pkg::cycles_t exp, input edm_pkg::cycles_t act);
		if (act !== exp)
			fail_run($sformatf("mismatch %s: expected %0d, actual %0d", name, exp, act));
	endtask

	task automatic check_logic(input string name, input logic exp, input logic act);
		if (act !== exp)
			fail_run($sformatf("mismatch %s: expected %b, actual %b", name, exp, act));
	endtask

	function automatic logic bridge_up(edm_pkg::gate_cmd_t g);
		return (g.buck1 == edm_pkg::HB_UP) || (g.buck2 == edm_pkg::HB_UP) || (g.res1 == edm_pkg::HB_UP)
			|| (g.res2 == edm_pkg::HB_UP);
	endfunction

	function automatic logic bridge_shorted(edm_pkg::gate_cmd_t g);
		return (g.buck1 == 2'b11) || (g.buck2 == 2'b11) || (g.res1 == 2'b11) || (g.res2 == 2'b11);
	endfunction

	function automatic logic gate_reached(int what);
		if (what == G_RES1_UP)
			return gate.res1 == edm_pkg::HB_UP;
		else if (what == G_RES1_OFF)
			return gate.res1 != edm_pkg::HB_UP;
		return gate.deion;
	endfunction

	// sum of toff, ton and WAIT_MAX over all rows, doubled, plus reset
	function automatic longint run_time_limit();
		longint total;
		total = 0;
		for (int i = 0; i < N_ROWS; i++)
			total += (ROWS[i].toff + ROWS[i].ton) * edm_pkg::CYCLES_PER_US + WAIT_MAX;
		return 2 * total + 10;
	endfunction

	task automatic drive_levels(input edm_pkg::sample_t cur, input edm_pkg::sample_t vol);
		sample_current = cur + edm_pkg::sample_t'($urandom % 4); // small noise, thresholds kept
		sample_voltage = vol + edm_pkg::sample_t'($urandom % 4);
	endtask

	task automatic wait_gate(input int what, input edm_pkg::cycles_t limit, output edm_pkg::cycles_t waited);
		waited = '0;
		while (!gate_reached(what))
		begin
			@(negedge clk);
			waited++;
			if (waited > limit)
				fail_run($sformatf("gate never reached condition %0d within %0d cycles", what, limit));
		end
	endtask

	task automatic run_row(input row_t r);
		string nm;
		edm_pkg::cycles_t waited;
		nm = $sformatf("%0s", r.name);
		drive_levels(r.cur_pre, r.vol_pre);
		if (!r.mon)
		begin
			machine_on = 1'b0; // only dropped while the dut sits in deion
			repeat ((r.toff + r.ton) * edm_pkg::CYCLES_PER_US) @(negedge clk);
			check_logic(nm, 1'b0, is_operation);
		end
		else
		begin
			if (!machine_on)
			begin
				check_logic(nm, 1'b0, is_operation);
				machine_on = 1'b1;
				@(negedge clk);
				check_logic(nm, 1'b1, is_operation); // one cycle later
			end
			if (r.cur_brk * 2 > MAX_CURRENT)
			begin
				check_logic(nm, 1'b1, is_operation);
				drive_levels(r.cur_brk, r.vol_brk);
				repeat (2) @(negedge clk);
				check_logic(nm, 1'b1, is_operation);
				@(negedge clk);
				check_logic(nm, 1'b0, is_operation); // trip after three cycles
				drive_levels(r.cur_pre, r.vol_pre);
			end
			else
			begin
				wait_gate(G_RES1_UP, toff * edm_pkg::CYCLES_PER_US + DEAD_TIME + 5, waited);
				waveform = r.wave; // new times apply from the next off period
				ton = r.ton;
				toff = r.toff;
				up1_cnt = '0;
				up2_cnt = '0;
				buck_allowed = (r.wave == edm_pkg::WAVE_BUCK_OPEN);
				brk_seen = 1'b0;
				drive_levels(r.cur_brk, r.vol_brk);
				if (r.vol_brk >= BRK_VOL)
				begin
					wait_gate(G_DEION, WAIT_MAX + DEAD_TIME + 5, waited); // no breakdown, timeout
					check_logic(nm, 1'b0, brk_seen);
				end
				else
				begin
					wait_gate(G_RES1_OFF, r.ton * edm_pkg::CYCLES_PER_US + BRK_TIME + 5, waited);
					check_bridge(nm, edm_pkg::HB_OFF, gate.res1);
					check_logic(nm, 1'b1, brk_seen);
					if ((r.wave == edm_pkg::WAVE_RES) && (waited < r.ton * edm_pkg::CYCLES_PER_US + BRK_TIME))
						fail_run($sformatf("%s: resistor pulse ended early after %0d cycles", nm, waited));
					wait_gate(G_DEION, r.ton * edm_pkg::CYCLES_PER_US + DEAD_TIME + 5, waited);
				end
				buck_allowed = 1'b0;
				drive_levels(r.cur_pre, r.vol_pre); // gap open again before the next wait
				check_cycles(nm, edm_pkg::cycles_t'(r.exp_up1), up1_cnt);
				check_cycles(nm, edm_pkg::cycles_t'(r.exp_up2), up2_cnt);
			end
		end
	endtask

	always @(posedge clk)
		low_cycles <= machine_on ? 0 : low_cycles + 1; // input stable at posedge

	// gate monitor, outputs settled since the rising edge
	always @(negedge clk)
	begin
		cyc++;
		if (is_breakdown)
			brk_seen = 1'b1;
		if (bridge_shorted(gate))
			fail_run("a half-bridge has both mosfets on");
		if ((low_cycles > 3) && bridge_up(gate))
			fail_run("a bridge is up while the machine is off");
		if (((gate.buck1 == edm_pkg::HB_UP) || (gate.buck2 == edm_pkg::HB_UP))
			&& (!buck_allowed || (gate.res1 != edm_pkg::HB_OFF)))
			fail_run("a buck leg is up outside a buck pulse");
		if (gate.deion)
		begin
			if (!deion_prev)
			begin
				if (idle_run < DEAD_TIME)
					fail_run("deion started without dead time before it");
				deion_len = '0;
				deion_exp = toff * edm_pkg::CYCLES_PER_US - 2 * DEAD_TIME;
			end
			deion_len++;
		end
		else if (deion_prev)
		begin
			check_cycles("off period", deion_exp, deion_len);
			after_deion = 1'b1;
		end
		if (gate == '0)
			idle_run++;
		else
		begin
			if (after_deion && (idle_run < DEAD_TIME))
				fail_run("deion ended without dead time after it");
			after_deion = 1'b0;
			idle_run = '0;
		end
		deion_prev = gate.deion;
		if (gate.buck1 == edm_pkg::HB_UP)
		begin
			if (b1_len == '0)
				b1_start = cyc;
			b1_len++;
		end
		else if (b1_len != '0)
		begin
			check_cycles("buck1 charge", CHARGE_TIME, b1_len);
			up1_cnt++;
			b1_len = '0;
		end
		if (gate.buck2 == edm_pkg::HB_UP)
		begin
			if (b2_len == '0)
				check_cycles("buck2 phase", BUCK_HALF, cyc - b1_start); // half period behind leg 1
			b2_len++;
		end
		else if (b2_len != '0)
		begin
			check_cycles("buck2 charge", CHARGE_TIME, b2_len);
			up2_cnt++;
			b2_len = '0;
		end
	end

	initial
	begin
		#(run_time_limit() * 100);
		fail_run("watchdog: the run timed out before all tests finished");
	end

	initial
	begin
		void'($urandom(32'h80c0));
		rst_n = 1'b0;
		machine_on = 1'b0;
		waveform = ROWS[0].wave;
		ton = ROWS[0].ton;
		toff = ROWS[0].toff;
		sample_current = '0;
		sample_voltage = 16'sd100;
		repeat (5) @(negedge clk);
		check_gate("reset", '0, gate);
		check_logic("reset", 1'b0, is_operation);
		check_logic("reset", 1'b0, is_breakdown);
		repeat (5) @(negedge clk);
		rst_n = 1'b1; // 10 cycles low
		@(negedge clk);
		check_gate("after reset", '0, gate);
		check_logic("after reset", 1'b0, is_operation);
		check_logic("after reset", 1'b0, is_breakdown);
		for (int i = 0; i < N_ROWS; i++)
			run_row(ROWS[i]);
		$display("Test passed");
		$finish;
	end

endmodule

// ==== edm_pulse.f ====
design/edm_pkg.sv
design/pulse_sequencer.sv
design/breakdown_detector.sv
design/buck_phase_gen.sv
design/gate_driver.sv
design/edm_pulse_top.sv
verification/tb_edm_pulse.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run tb_edm_pulse with verilator, result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f edm_pulse.f \
	--top-module tb_edm_pulse -o tb_edm_pulse \
	&& ./obj_dir/tb_edm_pulse > sim.log 2>&1 \
	|| echo "simulation build or run returned an error"

grep -qx "Test passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
